//--- controlCore.sv
`timescale 1ns/1ps

module controlCore import cpuPkg::*; (
        input  instrId  id,
        output ctrlWord ctrl
);

        always_comb begin
                // defaults, then per-instruction overrides
                ctrl.aluOp    = ALU_PASSB;
                ctrl.shiftOp  = SH_NONE;
                ctrl.useImm   = 1'b0;
                ctrl.wbSel    = WB_EXEC;
                ctrl.memOp    = MEM_NONE;
                ctrl.ledWrite = 1'b0;
                ctrl.enable   = 1'b1;
                ctrl.legal    = 1'b1;
                case (id)
                        NOP: begin
                                ctrl.wbSel = WB_NONE;
                        end
                        ADDR: begin
                                ctrl.aluOp = ALU_ADD;
                        end
                        SUBR: begin
                                ctrl.aluOp = ALU_SUB;
                        end
                        ANDR: begin
                                ctrl.aluOp = ALU_AND;
                        end
                        ORR: begin
                                ctrl.aluOp = ALU_OR;
                        end
                        XORR: begin
                                ctrl.aluOp = ALU_XOR;
                        end
                        ADDI: begin
                                ctrl.aluOp  = ALU_ADD;
                                ctrl.useImm = 1'b1;
                        end
                        SHL: begin
                                ctrl.shiftOp = SH_LEFT;
                                ctrl.useImm  = 1'b1;    // shift amount from imm
                        end
                        SHR: begin
                                ctrl.shiftOp = SH_RIGHT;
                                ctrl.useImm  = 1'b1;
                        end
                        SAR: begin
                                ctrl.shiftOp = SH_ARITH;
                                ctrl.useImm  = 1'b1;
                        end
                        LDW: begin
                                ctrl.aluOp  = ALU_ADD;
                                ctrl.useImm = 1'b1;
                                ctrl.memOp  = MEM_READ;
                                ctrl.wbSel  = WB_MEM;
                        end
                        STW: begin
                                ctrl.aluOp  = ALU_ADD;
                                ctrl.useImm = 1'b1;
                                ctrl.memOp  = MEM_WRITE;
                                ctrl.wbSel  = WB_NONE;
                        end
                        OUTLED: begin
                                ctrl.wbSel    = WB_NONE;
                                ctrl.ledWrite = 1'b1;
                        end
                        HALT: begin
                                ctrl.wbSel  = WB_NONE;
                                ctrl.enable = 1'b0;
                        end
                        default: begin
                                ctrl.wbSel = WB_NONE;
                                ctrl.legal = 1'b0;   // unknown number
                        end
                endcase
        end

        // led port and memory port are never driven by the same instruction
        always_comb begin
                ledMemExcl: assert final (!(ctrl.ledWrite && ctrl.memOp != MEM_NONE))
                        else $error("memOp and ledWrite both active for id %0d", id);
        end

endmodule

//--- cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; #(
        parameter int DATA_W   = 32,
        parameter int NUM_REGS = 16
) (
        input  logic              clk,
        input  logic              arstN,
        input  apbReq             hostReq,
        output apbRsp             hostRsp,
        output apbReq             memReq,
        input  apbRsp             memRsp,
        output logic [DATA_W-1:0] ledOut
);

        localparam int IDX_W = $clog2(NUM_REGS);

        instrWord          instr;
        ctrlWord           ctrl;
        logic [DATA_W-1:0] rs1Data, rs2Data, hostData;
        logic [DATA_W-1:0] execResult, memAddr, loadData, wdata;
        logic [IDX_W-1:0]  rs2Idx, regSel;
        logic              we, memStart, memDone, ledWe;

        // STW takes its store data from the rd field
        assign rs2Idx = (ctrl.memOp == MEM_WRITE) ? instr.iForm.rd : instr.rForm.rs2;

        controlCore u_ctrl (.id(instr.rForm.id), .ctrl(ctrl));

        regBank #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) u_regs (
                .clk(clk), .arstN(arstN), .rs1(instr.rForm.rs1), .rs2(rs2Idx),
                .rd(instr.rForm.rd), .hostSel(regSel), .we(we), .wdata(wdata),
                .rs1Data(rs1Data), .rs2Data(rs2Data), .hostData(hostData));

        execUnit #(.DATA_W(DATA_W)) u_exec (
                .instr(instr), .ctrl(ctrl), .rs1Data(rs1Data), .rs2Data(rs2Data),
                .result(execResult), .memAddr(memAddr));

        memAccess #(.DATA_W(DATA_W)) u_mem (
                .clk(clk), .arstN(arstN), .start(memStart), .ctrl(ctrl), .addr(memAddr),
                .storeData(rs2Data), .req(memReq), .rsp(memRsp), .loadData(loadData),
                .done(memDone));

        hostPort #(.NUM_REGS(NUM_REGS)) u_host (
                .clk(clk), .arstN(arstN), .req(hostReq), .rsp(hostRsp), .instr(instr),
                .ctrl(ctrl), .memStart(memStart), .memDone(memDone), .loadData(loadData),
                .execResult(execResult), .regRead(hostData), .regSel(regSel), .we(we),
                .wdata(wdata), .ledWe(ledWe));

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) ledOut <= '0;
                else if (ledWe) ledOut <= rs1Data;      // OUTLED
        end

endmodule

//--- cpuCore_testdata.txt
// columns: kind, instruction word or register index, address, expected value
// kind 1 instruction (expected is pslverr), 2 register read, 3 memory word, 4 ledOut, 0 end
1 0C200064 0 0
1 0C41FFFD 0 0
2 2 0 FFFFFFFD
1 08624000 0 0
1 0A824000 0 0
1 18A24000 0 0
1 1AC24000 0 0
1 28E24000 0 0
2 3 0 61
2 4 0 67
2 5 0 64
2 6 0 FFFFFFFD
2 7 0 FFFFFF99
1 1D020004 0 0
1 1F240008 0 0
1 21440001 0 0
1 0C020005 0 0
2 8 0 640
2 9 0 00FFFFFF
2 A 0 FFFFFFFE
2 0 0 0
1 50620008 0 0
1 50E40013 0 0
3 0 6C 61
3 0 10 FFFFFF99
1 4F620008 0 0
1 4F800010 0 0
1 4FA00040 0 0
2 B 0 61
2 C 0 FFFFFF99
2 D 0 C31000EF
1 8C080000 0 0
4 0 0 67
1 FE220001 0 1
2 1 0 64
1 96000000 0 0
1 0DC00007 0 1
2 E 0 0
2 1 0 64
0 0 0 0

//--- cpuPkg.sv
package cpuPkg;

        // instruction numbers at fixed values
        typedef enum logic [6:0] {
                NOP    = 7'd0,
                ADDR   = 7'd4,
                SUBR   = 7'd5,
                ANDR   = 7'd12,
                ORR    = 7'd13,
                XORR   = 7'd20,
                ADDI   = 7'd6,
                SHL    = 7'd14,
                SHR    = 7'd15,
                SAR    = 7'd16,
                LDW    = 7'd39,
                STW    = 7'd40,
                OUTLED = 7'd70,
                HALT   = 7'd75
        } instrId;

        typedef enum logic [3:0] {
                ALU_ADD   = 4'd2,
                ALU_AND   = 4'd3,
                ALU_SUB   = 4'd5,
                ALU_PASSB = 4'd12,
                ALU_OR    = 4'd13,
                ALU_XOR   = 4'd14
        } aluOp;

        typedef enum logic [2:0] {
                SH_NONE  = 3'd0,
                SH_ARITH = 3'd2,
                SH_LEFT  = 3'd3,
                SH_RIGHT = 3'd4
        } shiftOp;

        typedef enum logic [1:0] {WB_NONE = 2'd0, WB_EXEC = 2'd1, WB_MEM = 2'd2} wbSel;

        typedef enum logic [1:0] {MEM_NONE = 2'd0, MEM_READ = 2'd1, MEM_WRITE = 2'd2} memOp;

        typedef struct packed {
                aluOp   aluOp;
                shiftOp shiftOp;
                logic   useImm;         // operand b from immediate
                wbSel   wbSel;
                memOp   memOp;
                logic   ledWrite;
                logic   enable;         // low on halt
                logic   legal;
        } ctrlWord;

        typedef struct packed {
                instrId      id;
                logic [3:0]  rd;
                logic [3:0]  rs1;
                logic [3:0]  rs2;
                logic [12:0] pad;
        } rFormWord;

        typedef struct packed {
                instrId             id;
                logic [3:0]         rd;        // data source on STW
                logic [3:0]         rs1;
                logic signed [16:0] imm;
        } iFormWord;

        typedef union packed {
                rFormWord rForm;
                iFormWord iForm;
        } instrWord;

        typedef struct packed {
                logic [31:0] paddr;
                logic        psel;
                logic        penable;
                logic        pwrite;
                logic [31:0] pwdata;
        } apbReq;

        typedef struct packed {
                logic [31:0] prdata;
                logic        pready;
                logic        pslverr;
        } apbRsp;

        // register n sits at base + 4n, address 0 takes instructions
        localparam logic [31:0] REG_ADDR_BASE = 32'h0000_0100;

endpackage

//--- execUnit.sv
`timescale 1ns/1ps

module execUnit import cpuPkg::*; #(
        parameter int DATA_W = 32
) (
        input  instrWord          instr,
        input  ctrlWord           ctrl,
        input  logic [DATA_W-1:0] rs1Data,
        input  logic [DATA_W-1:0] rs2Data,
        output logic [DATA_W-1:0] result,
        output logic [DATA_W-1:0] memAddr
);

        logic [DATA_W-1:0] immExt;
        logic [DATA_W-1:0] opA;
        logic [DATA_W-1:0] opB;
        logic [DATA_W-1:0] aluOut;
        logic [DATA_W-1:0] shOut;
        logic [4:0]        shAmt;

        // sign extend the 17-bit immediate
        assign immExt = {{(DATA_W-17){instr.iForm.imm[16]}}, instr.iForm.imm};

        assign opA   = rs1Data;
        assign opB   = ctrl.useImm ? immExt : rs2Data;
        assign shAmt = opB[4:0];

        always_comb begin
                case (ctrl.aluOp)
                        ALU_ADD: aluOut = opA + opB;
                        ALU_SUB: aluOut = opA - opB;
                        ALU_AND: aluOut = opA & opB;
                        ALU_OR:  aluOut = opA | opB;
                        ALU_XOR: aluOut = opA ^ opB;
                        default: aluOut = opB;          // pass b
                endcase
        end

        // barrel shifter works on operand a
        always_comb begin
                case (ctrl.shiftOp)
                        SH_LEFT:  shOut = opA << shAmt;
                        SH_RIGHT: shOut = opA >> shAmt;
                        SH_ARITH: shOut = DATA_W'($signed(opA) >>> shAmt);
                        default:  shOut = opA;
                endcase
        end

        assign result  = (ctrl.shiftOp == SH_NONE) ? aluOut : shOut;
        assign memAddr = rs1Data + immExt;     // load/store effective address

endmodule

//--- hostPort.sv
`timescale 1ns/1ps

module hostPort import cpuPkg::*; #(
        parameter int NUM_REGS = 16
) (
        input  logic                        clk,
        input  logic                        arstN,
        input  apbReq                       req,
        output apbRsp                       rsp,
        output instrWord                    instr,
        input  ctrlWord                     ctrl,
        output logic                        memStart,
        input  logic                        memDone,
        input  logic [31:0]                 loadData,
        input  logic [31:0]                 execResult,
        input  logic [31:0]                 regRead,
        output logic [$clog2(NUM_REGS)-1:0] regSel,
        output logic                        we,
        output logic [31:0]                 wdata,
        output logic                        ledWe
);

        localparam int IDX_W = $clog2(NUM_REGS);

        logic [31:0] regOff;
        logic        access;
        logic        isReg;
        logic        instrWr;
        logic        regRd;
        logic        bad;
        logic        memInstr;
        logic        pending;
        logic        halted;

        assign access  = req.psel && req.penable;
        assign regOff  = req.paddr - REG_ADDR_BASE;   // wraps above range below base
        assign isReg   = (regOff < 4 * NUM_REGS) && (regOff[1:0] == 2'b00);
        assign regSel  = regOff[IDX_W+1:2];
        assign instrWr = access && req.pwrite && (req.paddr == '0);
        assign regRd   = access && !req.pwrite && isReg;

        assign instr    = instrWord'(req.pwdata);
        assign bad      = !ctrl.legal || halted;
        assign memInstr = instrWr && !bad && (ctrl.memOp != MEM_NONE);
        assign memStart = memInstr && !pending;

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        pending <= 1'b0;
                        halted  <= 1'b0;
                end else begin
                        if (memStart) pending <= 1'b1;
                        else if (memDone) pending <= 1'b0;
                        if (instrWr && !bad && !ctrl.enable) halted <= 1'b1;  // until reset
                end
        end

        assign rsp.pready  = access && !(memInstr && !memDone);   // wait on memory only
        assign rsp.pslverr = access && (instrWr ? bad : !regRd);
        assign rsp.prdata  = regRd ? regRead : '0;

        assign we    = instrWr && !bad && (ctrl.wbSel != WB_NONE) && rsp.pready;
        assign wdata = (ctrl.wbSel == WB_MEM) ? loadData : execResult;
        assign ledWe = instrWr && !bad && ctrl.ledWrite;

        noErrWrite: assert property (@(posedge clk) disable iff (!arstN)
                we |-> !rsp.pslverr)
                else $error("register write-back on an erroring instruction");

endmodule

//--- memAccess.sv
`timescale 1ns/1ps

module memAccess import cpuPkg::*; #(
        parameter int DATA_W = 32
) (
        input  logic              clk,
        input  logic              arstN,
        input  logic              start,
        input  ctrlWord           ctrl,
        input  logic [DATA_W-1:0] addr,
        input  logic [DATA_W-1:0] storeData,
        output apbReq             req,
        input  apbRsp             rsp,
        output logic [DATA_W-1:0] loadData,
        output logic              done
);

        typedef enum logic [1:0] {IDLE, SETUP, ACCESS} memState;

        memState           state;
        logic [DATA_W-1:0] addrQ;
        logic [DATA_W-1:0] dataQ;
        logic [DATA_W-1:0] loadQ;
        logic              writeQ;

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        state <= IDLE;
                end else begin
                        case (state)
                                IDLE:    if (start) state <= SETUP;
                                SETUP:   state <= ACCESS;
                                ACCESS:  if (rsp.pready) state <= IDLE;
                                default: state <= IDLE;
                        endcase
                end
        end

        // payload held through the whole transfer
        always_ff @(posedge clk) begin
                if (state == IDLE && start) begin
                        addrQ  <= addr;
                        dataQ  <= storeData;
                        writeQ <= (ctrl.memOp == MEM_WRITE);
                end
                if (done && !writeQ) loadQ <= rsp.prdata;
        end

        assign req.paddr   = addrQ;
        assign req.pwdata  = dataQ;
        assign req.pwrite  = writeQ;
        assign req.psel    = (state != IDLE);
        assign req.penable = (state == ACCESS);

        assign done     = (state == ACCESS) && rsp.pready;
        assign loadData = (state == ACCESS) ? rsp.prdata : loadQ;  // live on the done cycle

        waitStable: assert property (@(posedge clk) disable iff (!arstN)
                req.penable && !rsp.pready |=> $stable(req))
                else $error("memory request changed during a wait state");

endmodule

//--- regBank.sv
`timescale 1ns/1ps

module regBank #(
        parameter int DATA_W   = 32,
        parameter int NUM_REGS = 16
) (
        input  logic                        clk,
        input  logic                        arstN,
        input  logic [$clog2(NUM_REGS)-1:0] rs1,
        input  logic [$clog2(NUM_REGS)-1:0] rs2,
        input  logic [$clog2(NUM_REGS)-1:0] rd,
        input  logic [$clog2(NUM_REGS)-1:0] hostSel,
        input  logic                        we,
        input  logic [DATA_W-1:0]           wdata,
        output logic [DATA_W-1:0]           rs1Data,
        output logic [DATA_W-1:0]           rs2Data,
        output logic [DATA_W-1:0]           hostData
);

        logic [DATA_W-1:0] regs [NUM_REGS];

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && rd != '0) begin     // r0 stays zero
                        regs[rd] <= wdata;
                end
        end

        assign rs1Data  = regs[rs1];
        assign rs2Data  = regs[rs2];
        assign hostData = regs[hostSel];

endmodule

//--- tbCpuCore.sv
`timescale 1ns/1ps

module tbCpuCore import cpuPkg::*; ();

        localparam int MAX_VEC  = 64;
        localparam int WAIT_MAX = 50;

        logic        clk = 1'b0;
        logic        arstN;
        apbReq       hostReq;
        apbRsp       hostRsp;
        apbReq       memReq;
        apbRsp       memRsp;
        logic [31:0] ledOut;

        logic [31:0] vec [MAX_VEC*4];
        logic [31:0] mem [256];
        logic [7:0]  lfsr = 8'd45;
        int          errCount = 0;
        int          testCount = 0;
        int          failCount = 0;
        int          waitLeft;
        int          drawnWaits = 0;
        logic        timedOut = 1'b0;
        apbReq       heldReq;

        cpuCore #(.DATA_W(32), .NUM_REGS(16)) u_dut (
                .clk(clk), .arstN(arstN), .hostReq(hostReq), .hostRsp(hostRsp),
                .memReq(memReq), .memRsp(memRsp), .ledOut(ledOut));

        always #2 clk = ~clk;

        function automatic logic [7:0] lfsrStep(input logic [7:0] s);
                return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};     // x^8+x^6+x^5+x^4+1
        endfunction

        // two bits per transfer, so 0 to 3 wait states
        task automatic drawWaits(output int n);
                logic [1:0] bits;
                for (int b = 0; b < 2; b++) begin
                        lfsr    = lfsrStep(lfsr);
                        bits[b] = lfsr[0];
                end
                n = bits;
        endtask

        // data memory on the requester port
        always @(negedge clk) begin
                if (!arstN) begin
                        memRsp = '0;
                end else if (memReq.psel && !memReq.penable) begin
                        drawWaits(waitLeft);
                        drawnWaits    = waitLeft;
                        heldReq       = memReq;
                        memRsp.pready = 1'b0;
                end else if (memReq.psel) begin
                        if ({memReq.paddr, memReq.pwrite, memReq.pwdata} !==
                            {heldReq.paddr, heldReq.pwrite, heldReq.pwdata}) begin
                                $display("memory request changed during a wait state at %0t", $time);
                                errCount++;
                        end
                        if (waitLeft > 0) begin
                                waitLeft--;
                        end else begin
                                memRsp.pready = 1'b1;
                                if (memReq.pwrite) mem[memReq.paddr[9:2]] = memReq.pwdata;
                                else memRsp.prdata = mem[memReq.paddr[9:2]];
                        end
                end else begin
                        memRsp.pready = 1'b0;
                end
        end

        // setup, then access until pready, sampled a ns after each falling edge
        task automatic hostXfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                                output apbRsp rsp, output int waits);
                @(negedge clk);
                hostReq.paddr  = addr;
                hostReq.pwrite = wr;
                hostReq.pwdata = data;
                hostReq.psel   = 1'b1;
                @(negedge clk);
                hostReq.penable = 1'b1;
                waits = 0;
                #1;
                while (!hostRsp.pready && waits < WAIT_MAX) begin
                        @(negedge clk);
                        #1;
                        waits++;
                end
                rsp = hostRsp;
                if (!hostRsp.pready) begin
                        $display("host transfer to address %h never saw pready", addr);
                        errCount++;
                        timedOut = 1'b1;
                end
                @(negedge clk);
                hostReq.psel    = 1'b0;
                hostReq.penable = 1'b0;
        endtask

        task automatic checkData(input string name, input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("MISMATCH %s got %h expected %h", name, got, exp);
                        errCount++;
                end
        endtask

        task automatic checkRsp(input string name, input apbRsp got, input apbRsp exp);
                if (got !== exp) begin
                        $display("MISMATCH %s got prdata %h pready %h pslverr %h, expected %h %h %h",
                                 name, got.prdata, got.pready, got.pslverr,
                                 exp.prdata, exp.pready, exp.pslverr);
                        errCount++;
                end
        endtask

        task automatic checkMem(input logic [31:0] addr, input logic [31:0] exp);
                if (mem[addr[9:2]] !== exp) begin
                        $display("MISMATCH mem[%h] got %h expected %h", addr, mem[addr[9:2]], exp);
                        errCount++;
                end
        endtask

        task automatic checkWaits(input int t, input int waits, input int expWaits);
                if (waits != expWaits) begin
                        $display("test %0d took %0d wait states instead of %0d",
                                 t, waits, expWaits);
                        errCount++;
                end
        endtask

        initial begin
                apbRsp       rsp;
                apbRsp       expRsp;
                instrWord    iw;
                int          waits;
                int          errBefore;
                logic        isMem;
                logic [31:0] kind;
                logic [31:0] arg;
                logic [31:0] expVal;

                hostReq = '0;
                memRsp  = '0;
                arstN   = 1'b0;
                for (int i = 0; i < 256; i++) begin
                        mem[i] = 32'hC300_0000 | (i << 16) | (~i & 32'hFF);
                end
                for (int i = 0; i < MAX_VEC * 4; i++) begin
                        vec[i] = '0;
                end
                $readmemh("cpuCore_testdata.txt", vec);
                repeat (2) @(posedge clk);
                @(negedge clk);
                arstN = 1'b1;

                for (int t = 0; t < MAX_VEC && vec[4*t] != 0 && !timedOut; t++) begin
                        kind      = vec[4*t];
                        iw        = vec[4*t+1];
                        arg       = vec[4*t+2];
                        expVal    = vec[4*t+3];
                        errBefore = errCount;
                        case (kind)
                                1: begin
                                        hostXfer(1'b1, 32'h0, iw, rsp, waits);
                                        if (!timedOut) begin
                                                expRsp = '{prdata: '0, pready: 1'b1,
                                                           pslverr: expVal[0]};
                                                checkRsp("hostRsp", rsp, expRsp);
                                                // setup and first access, then memory waits
                                                isMem = (iw.rForm.id inside {LDW, STW}) &&
                                                        !expVal[0];
                                                checkWaits(t, waits, isMem ? 2 + drawnWaits : 0);
                                        end
                                end
                                2: begin
                                        hostXfer(1'b0, REG_ADDR_BASE + 4 * iw, '0, rsp, waits);
                                        if (!timedOut) begin
                                                expRsp = '{prdata: expVal, pready: 1'b1,
                                                           pslverr: 1'b0};
                                                checkRsp("hostRsp", rsp, expRsp);
                                                checkWaits(t, waits, 0);
                                        end
                                end
                                3: checkMem(arg, expVal);
                                4: checkData("ledOut", ledOut, expVal);
                                default: begin
                                        $display("vector %0d has unknown kind %0h", t, kind);
                                        errCount++;
                                end
                        endcase
                        testCount++;
                        if (errCount == errBefore) begin
                                $display("test %0d kind %0d passed", t, kind);
                        end else begin
                                failCount++;
                                $display("test %0d kind %0d FAILED", t, kind);
                        end
                end

                $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                         testCount, testCount - failCount, failCount, errCount);
                if (errCount == 0 && testCount > 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

//--- verilog.f
cpuPkg.sv
controlCore.sv
regBank.sv
execUnit.sv
memAccess.sv
hostPort.sv
cpuCore.sv
tbCpuCore.sv
